/* Bender.yml */
package:
  name: mem_stage

sources:
  - files:
      - hw/mem_pkg.sv
      - hw/cp0_forward.sv
      - hw/exc_resolve.sv
      - hw/llbit_reg.sv
      - hw/lsu_align.sv
      - hw/mem_ctrl.sv
      - hw/mem_stage.sv
  - target: test
    include_dirs:
      - include
    files:
      - sim/tb_mem_stage.sv

/* hw/cp0_forward.sv */
// cp0 status and cause forwarding
`timescale 1ns/1ps
`default_nettype none

module cp0_forward (
    input  wire logic [mem_pkg::XLEN-1:0]       cp0_status_i,
    input  wire logic [mem_pkg::XLEN-1:0]       cp0_cause_i,
    input  wire logic                           wb_cp0_we_i,
    input  wire logic [mem_pkg::REG_ADDR_W-1:0] wb_cp0_addr_i,
    input  wire logic [mem_pkg::XLEN-1:0]       wb_cp0_data_i,
    output logic      [mem_pkg::XLEN-1:0]       status_o,
    output logic      [mem_pkg::XLEN-1:0]       cause_o
);

    logic wr_status;
    logic wr_cause;

    assign wr_status = wb_cp0_we_i && (wb_cp0_addr_i == mem_pkg::CP0_REG_STATUS);
    assign wr_cause  = wb_cp0_we_i && (wb_cp0_addr_i == mem_pkg::CP0_REG_CAUSE);

    // status is fully writable
    assign status_o = wr_status ? wb_cp0_data_i : cp0_status_i;

    // only the software-writable cause fields take the write-back value
    always_comb begin
        cause_o = cp0_cause_i;
        if (wr_cause) begin
            cause_o = (cp0_cause_i & ~mem_pkg::CAUSE_WMASK)
                    | (wb_cp0_data_i & mem_pkg::CAUSE_WMASK);
        end
    end

endmodule

`default_nettype wire

/* hw/exc_resolve.sv */
// exception priority resolution
`timescale 1ns/1ps
`default_nettype none

module exc_resolve (
    input  wire logic                            inst_valid_i,
    input  wire logic [mem_pkg::EXC_FLAGS_W-1:0] exc_flags_i,
    input  wire logic [mem_pkg::XLEN-1:0]        status_i,
    input  wire logic [mem_pkg::XLEN-1:0]        cause_i,
    output mem_pkg::exc_code_e                   exc_o
);

    logic int_pending;

    // masked pending lines, EXL clear, IE set
    assign int_pending = ((cause_i[15:8] & status_i[15:8]) != 8'h00)
                      && !status_i[1]
                      && status_i[0];

    always_comb begin
        exc_o = mem_pkg::EXC_NONE;
        if (inst_valid_i) begin
            if (int_pending) begin
                exc_o = mem_pkg::EXC_INT;
            end else if (exc_flags_i[mem_pkg::FLAG_SYS]) begin
                exc_o = mem_pkg::EXC_SYS;
            end else if (exc_flags_i[mem_pkg::FLAG_RI]) begin
                exc_o = mem_pkg::EXC_RI;
            end else if (exc_flags_i[mem_pkg::FLAG_TR]) begin
                exc_o = mem_pkg::EXC_TR;
            end else if (exc_flags_i[mem_pkg::FLAG_OV]) begin
                exc_o = mem_pkg::EXC_OV;
            end else if (exc_flags_i[mem_pkg::FLAG_ERET]) begin
                exc_o = mem_pkg::EXC_ERET;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/llbit_reg.sv */
// load-linked bit register
`timescale 1ns/1ps
`default_nettype none

module llbit_reg (
    input  wire logic clk,
    input  wire logic rst_i,
    input  wire logic set_i,
    input  wire logic clear_i,
    output logic      llbit_o
);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            llbit_o <= 1'b0;
        end else if (clear_i) begin
            // clear has priority
            llbit_o <= 1'b0;
        end else if (set_i) begin
            llbit_o <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hw/lsu_align.sv */
// byte lane alignment and load extension
`timescale 1ns/1ps
`default_nettype none

module lsu_align (
    input  wire mem_pkg::mem_op_e                op_i,
    input  wire logic [1:0]                      addr_lo_i,
    input  wire logic [mem_pkg::XLEN-1:0]        reg2_i,
    input  wire logic [mem_pkg::XLEN-1:0]        rdata_i,
    output logic      [mem_pkg::SEL_W-1:0]       sel_o,
    output logic      [mem_pkg::XLEN-1:0]        wdata_o,
    output logic      [mem_pkg::XLEN-1:0]        load_data_o
);

    logic [7:0]  rd_byte;
    logic [15:0] rd_half;
    logic [3:0]  byte_sel;
    logic [3:0]  half_sel;

    // lane k holds byte k
    assign rd_byte  = rdata_i[8*addr_lo_i +: 8];
    assign rd_half  = addr_lo_i[1] ? rdata_i[31:16] : rdata_i[15:0];
    assign byte_sel = 4'b0001 << addr_lo_i;
    assign half_sel = addr_lo_i[1] ? 4'b1100 : 4'b0011;

    always_comb begin
        case (op_i)
            mem_pkg::OP_LB, mem_pkg::OP_LBU, mem_pkg::OP_SB: begin
                sel_o = byte_sel;
            end
            mem_pkg::OP_LH, mem_pkg::OP_LHU, mem_pkg::OP_SH: begin
                sel_o = half_sel;
            end
            mem_pkg::OP_LW, mem_pkg::OP_SW, mem_pkg::OP_LL, mem_pkg::OP_SC: begin
                sel_o = 4'b1111;
            end
            default: begin
                sel_o = 4'b0000;
            end
        endcase
    end

    // replicate so every enabled lane sees the data
    always_comb begin
        case (op_i)
            mem_pkg::OP_SB: begin
                wdata_o = {4{reg2_i[7:0]}};
            end
            mem_pkg::OP_SH: begin
                wdata_o = {2{reg2_i[15:0]}};
            end
            default: begin
                wdata_o = reg2_i;
            end
        endcase
    end

    always_comb begin
        case (op_i)
            mem_pkg::OP_LB: begin
                load_data_o = {{24{rd_byte[7]}}, rd_byte};
            end
            mem_pkg::OP_LBU: begin
                load_data_o = {24'h00_0000, rd_byte};
            end
            mem_pkg::OP_LH: begin
                load_data_o = {{16{rd_half[15]}}, rd_half};
            end
            mem_pkg::OP_LHU: begin
                load_data_o = {16'h0000, rd_half};
            end
            default: begin
                // lw and ll take the full word
                load_data_o = rdata_i;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/mem_ctrl.sv */
// memory access control
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl (
    input  wire logic                       inst_valid_i,
    input  wire mem_pkg::mem_op_e           op_i,
    input  wire logic [mem_pkg::XLEN-1:0]   mem_addr_i,
    input  wire mem_pkg::exc_code_e         exc_i,
    input  wire logic                       llbit_i,
    input  wire logic [mem_pkg::XLEN-1:0]   load_data_i,
    input  wire logic                       wreg_i,
    input  wire logic [mem_pkg::XLEN-1:0]   wdata_i,
    input  wire logic                       rvalid_i,
    input  wire logic                       bvalid_i,
    output logic                            ce_o,
    output logic                            we_o,
    output logic      [mem_pkg::XLEN-1:0]   addr_o,
    output logic                            stall_o,
    output logic                            wreg_o,
    output logic      [mem_pkg::XLEN-1:0]   wdata_o,
    output logic                            ll_set_o,
    output logic                            ll_clear_o
);

    logic is_load;
    logic is_store;
    logic sc_ok;
    logic complete;

    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        case (op_i)
            mem_pkg::OP_LB, mem_pkg::OP_LBU, mem_pkg::OP_LH, mem_pkg::OP_LHU,
            mem_pkg::OP_LW, mem_pkg::OP_LL: begin
                is_load = 1'b1;
            end
            mem_pkg::OP_SB, mem_pkg::OP_SH, mem_pkg::OP_SW: begin
                is_store = 1'b1;
            end
            mem_pkg::OP_SC: begin
                // sc only writes while the link holds
                is_store = llbit_i;
            end
            default: begin
            end
        endcase
    end

    // an exception cancels the access
    assign ce_o   = inst_valid_i && (exc_i == mem_pkg::EXC_NONE) && (is_load || is_store);
    assign we_o   = ce_o && is_store;
    assign addr_o = {mem_addr_i[mem_pkg::XLEN-1:2], 2'b00};

    // hold until the matching response shows up
    assign stall_o  = ce_o && (we_o ? !bvalid_i : !rvalid_i);
    assign complete = inst_valid_i && !stall_o;

    assign sc_ok = ce_o && (op_i == mem_pkg::OP_SC);

    assign ll_set_o   = complete && ce_o && (op_i == mem_pkg::OP_LL);
    assign ll_clear_o = complete && (sc_ok || (exc_i == mem_pkg::EXC_ERET));

    assign wreg_o = wreg_i && inst_valid_i;

    always_comb begin
        if (is_load) begin
            wdata_o = load_data_i;
        end else if (op_i == mem_pkg::OP_SC) begin
            wdata_o = {{(mem_pkg::XLEN-1){1'b0}}, sc_ok};
        end else begin
            wdata_o = wdata_i;
        end
    end

endmodule

`default_nettype wire

/* hw/mem_pkg.sv */
// memory stage shared definitions
`default_nettype none

package mem_pkg;

    localparam int unsigned XLEN        = 32;
    localparam int unsigned REG_ADDR_W  = 5;
    localparam int unsigned SEL_W       = 4;
    localparam int unsigned EXC_FLAGS_W = 5;

    // execute-stage exception flag positions
    localparam int unsigned FLAG_SYS  = 0;
    localparam int unsigned FLAG_RI   = 1;
    localparam int unsigned FLAG_TR   = 2;
    localparam int unsigned FLAG_OV   = 3;
    localparam int unsigned FLAG_ERET = 4;

    localparam logic [REG_ADDR_W-1:0] CP0_REG_STATUS = 5'd12;
    localparam logic [REG_ADDR_W-1:0] CP0_REG_CAUSE  = 5'd13;

    // IP1:0, WP and IV
    localparam logic [XLEN-1:0] CAUSE_WMASK = 32'h00c0_0300;

    typedef enum logic [3:0] {
        OP_NOP, OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW,
        OP_SB, OP_SH, OP_SW, OP_LL, OP_SC
    } mem_op_e;

    typedef enum logic [4:0] {
        EXC_NONE = 5'd0,
        EXC_INT  = 5'd1,
        EXC_SYS  = 5'd8,
        EXC_RI   = 5'd10,
        EXC_OV   = 5'd12,
        EXC_TR   = 5'd13,
        EXC_ERET = 5'd14
    } exc_code_e;

endpackage

`default_nettype wire

/* hw/mem_stage.sv */
// memory access stage top
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  wire logic                             clk,
    input  wire logic                             rst_i,
    input  wire logic                             inst_valid_i,
    input  wire mem_pkg::mem_op_e                 op_i,
    input  wire logic [mem_pkg::XLEN-1:0]         mem_addr_i,
    input  wire logic [mem_pkg::XLEN-1:0]         reg2_i,
    input  wire logic [mem_pkg::REG_ADDR_W-1:0]   wd_i,
    input  wire logic                             wreg_i,
    input  wire logic [mem_pkg::XLEN-1:0]         wdata_i,
    input  wire logic [mem_pkg::EXC_FLAGS_W-1:0]  exc_flags_i,
    input  wire logic [mem_pkg::XLEN-1:0]         cp0_status_i,
    input  wire logic [mem_pkg::XLEN-1:0]         cp0_cause_i,
    input  wire logic                             wb_cp0_we_i,
    input  wire logic [mem_pkg::REG_ADDR_W-1:0]   wb_cp0_addr_i,
    input  wire logic [mem_pkg::XLEN-1:0]         wb_cp0_data_i,
    input  wire logic [mem_pkg::XLEN-1:0]         dmem_rdata_i,
    input  wire logic                             dmem_rvalid_i,
    input  wire logic                             dmem_bvalid_i,
    output logic                                  dmem_ce_o,
    output logic                                  dmem_we_o,
    output logic      [mem_pkg::XLEN-1:0]         dmem_addr_o,
    output logic      [mem_pkg::SEL_W-1:0]        dmem_sel_o,
    output logic      [mem_pkg::XLEN-1:0]         dmem_wdata_o,
    output logic                                  stall_o,
    output logic      [mem_pkg::REG_ADDR_W-1:0]   wd_o,
    output logic                                  wreg_o,
    output logic      [mem_pkg::XLEN-1:0]         wdata_o,
    output mem_pkg::exc_code_e                    exc_o
);

    logic [mem_pkg::XLEN-1:0] status_fwd;
    logic [mem_pkg::XLEN-1:0] cause_fwd;
    logic [mem_pkg::XLEN-1:0] load_data;
    logic                     llbit;
    logic                     ll_set;
    logic                     ll_clear;

    assign wd_o = wd_i;

    cp0_forward u_cp0_forward (
        .cp0_status_i  (cp0_status_i),
        .cp0_cause_i   (cp0_cause_i),
        .wb_cp0_we_i   (wb_cp0_we_i),
        .wb_cp0_addr_i (wb_cp0_addr_i),
        .wb_cp0_data_i (wb_cp0_data_i),
        .status_o      (status_fwd),
        .cause_o       (cause_fwd)
    );

    exc_resolve u_exc_resolve (
        .inst_valid_i (inst_valid_i),
        .exc_flags_i  (exc_flags_i),
        .status_i     (status_fwd),
        .cause_i      (cause_fwd),
        .exc_o        (exc_o)
    );

    llbit_reg u_llbit_reg (
        .clk     (clk),
        .rst_i   (rst_i),
        .set_i   (ll_set),
        .clear_i (ll_clear),
        .llbit_o (llbit)
    );

    lsu_align u_lsu_align (
        .op_i        (op_i),
        .addr_lo_i   (mem_addr_i[1:0]),
        .reg2_i      (reg2_i),
        .rdata_i     (dmem_rdata_i),
        .sel_o       (dmem_sel_o),
        .wdata_o     (dmem_wdata_o),
        .load_data_o (load_data)
    );

    mem_ctrl u_mem_ctrl (
        .inst_valid_i (inst_valid_i),
        .op_i         (op_i),
        .mem_addr_i   (mem_addr_i),
        .exc_i        (exc_o),
        .llbit_i      (llbit),
        .load_data_i  (load_data),
        .wreg_i       (wreg_i),
        .wdata_i      (wdata_i),
        .rvalid_i     (dmem_rvalid_i),
        .bvalid_i     (dmem_bvalid_i),
        .ce_o         (dmem_ce_o),
        .we_o         (dmem_we_o),
        .addr_o       (dmem_addr_o),
        .stall_o      (stall_o),
        .wreg_o       (wreg_o),
        .wdata_o      (wdata_o),
        .ll_set_o     (ll_set),
        .ll_clear_o   (ll_clear)
    );

endmodule

`default_nettype wire

/* mem_stage.f */
+incdir+include
hw/mem_pkg.sv
hw/cp0_forward.sv
hw/exc_resolve.sv
hw/llbit_reg.sv
hw/lsu_align.sv
hw/mem_ctrl.sv
hw/mem_stage.sv
sim/tb_mem_stage.sv

/* include/tb_lfsr.svh */
// testbench lfsr step
`ifndef TB_LFSR_SVH
`define TB_LFSR_SVH

// fibonacci form, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic fb;
    fb = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], fb};
endfunction

`endif

/* sim/tb_mem_stage.sv */
// memory stage testbench
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage;

    logic               clk;
    logic               rst_i;
    logic               inst_valid_i;
    mem_pkg::mem_op_e   op_i;
    logic [31:0]        mem_addr_i;
    logic [31:0]        reg2_i;
    logic [4:0]         wd_i;
    logic               wreg_i;
    logic [31:0]        wdata_i;
    logic [4:0]         exc_flags_i;
    logic [31:0]        cp0_status_i;
    logic [31:0]        cp0_cause_i;
    logic               wb_cp0_we_i;
    logic [4:0]         wb_cp0_addr_i;
    logic [31:0]        wb_cp0_data_i;
    logic [31:0]        dmem_rdata_i;
    logic               dmem_rvalid_i;
    logic               dmem_bvalid_i;
    logic               dmem_ce_o;
    logic               dmem_we_o;
    logic [31:0]        dmem_addr_o;
    logic [3:0]         dmem_sel_o;
    logic [31:0]        dmem_wdata_o;
    logic               stall_o;
    logic [4:0]         wd_o;
    logic               wreg_o;
    logic [31:0]        wdata_o;
    mem_pkg::exc_code_e exc_o;

    logic [31:0] mem [0:15];
    logic [31:0] lfsr_q;
    logic        link_m;
    int          errors;
    int          sva_errors;
    int          tests;
    int          test_start;

    mem_pkg::mem_op_e load_list [5] = '{mem_pkg::OP_LB, mem_pkg::OP_LBU, mem_pkg::OP_LH,
                                        mem_pkg::OP_LHU, mem_pkg::OP_LW};
    mem_pkg::mem_op_e store_list [3] = '{mem_pkg::OP_SB, mem_pkg::OP_SH, mem_pkg::OP_SW};

    `include "tb_lfsr.svh"

    mem_stage u_mem_stage (
        .clk           (clk),
        .rst_i         (rst_i),
        .inst_valid_i  (inst_valid_i),
        .op_i          (op_i),
        .mem_addr_i    (mem_addr_i),
        .reg2_i        (reg2_i),
        .wd_i          (wd_i),
        .wreg_i        (wreg_i),
        .wdata_i       (wdata_i),
        .exc_flags_i   (exc_flags_i),
        .cp0_status_i  (cp0_status_i),
        .cp0_cause_i   (cp0_cause_i),
        .wb_cp0_we_i   (wb_cp0_we_i),
        .wb_cp0_addr_i (wb_cp0_addr_i),
        .wb_cp0_data_i (wb_cp0_data_i),
        .dmem_rdata_i  (dmem_rdata_i),
        .dmem_rvalid_i (dmem_rvalid_i),
        .dmem_bvalid_i (dmem_bvalid_i),
        .dmem_ce_o     (dmem_ce_o),
        .dmem_we_o     (dmem_we_o),
        .dmem_addr_o   (dmem_addr_o),
        .dmem_sel_o    (dmem_sel_o),
        .dmem_wdata_o  (dmem_wdata_o),
        .stall_o       (stall_o),
        .wd_o          (wd_o),
        .wreg_o        (wreg_o),
        .wdata_o       (wdata_o),
        .exc_o         (exc_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // idle stage keeps the bus quiet
    idle_quiet: assert property (@(posedge clk) disable iff (rst_i)
        !inst_valid_i |-> !dmem_ce_o && !stall_o && !wreg_o)
        else begin
            $display("bus request, stall or write-back seen with no valid instruction");
            sva_errors++;
        end

    held_req: assert property (@(posedge clk) disable iff (rst_i)
        stall_o |=> dmem_ce_o && $stable(dmem_addr_o) && $stable(dmem_sel_o))
        else begin
            $display("bus request changed while the stage was stalled");
            sva_errors++;
        end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic draw(input int nbits, output logic [31:0] v);
        int i;
        v = 32'h0;
        for (i = 0; i < nbits; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors == test_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - test_start);
        end
        test_start = errors;
    endtask

    function automatic logic legal_off(input mem_pkg::mem_op_e op, input logic [1:0] off);
        if (op inside {mem_pkg::OP_LH, mem_pkg::OP_LHU, mem_pkg::OP_SH}) begin
            return !off[0];
        end
        if (op inside {mem_pkg::OP_LW, mem_pkg::OP_SW}) begin
            return off == 2'd0;
        end
        return 1'b1;
    endfunction

    // a lane is enabled when the addressed byte or halfword covers it
    function automatic logic [3:0] exp_sel(input mem_pkg::mem_op_e op, input logic [1:0] off);
        logic [3:0] s;
        int         k;
        for (k = 0; k < 4; k++) begin
            if (op inside {mem_pkg::OP_LB, mem_pkg::OP_LBU, mem_pkg::OP_SB}) begin
                s[k] = (k == off);
            end else if (op inside {mem_pkg::OP_LH, mem_pkg::OP_LHU, mem_pkg::OP_SH}) begin
                s[k] = ((k / 2) == off[1]);
            end else begin
                s[k] = 1'b1;
            end
        end
        return s;
    endfunction

    function automatic logic [31:0] exp_store(input mem_pkg::mem_op_e op, input logic [31:0] r2);
        if (op == mem_pkg::OP_SB) begin
            return r2[7:0] * 32'h0101_0101;
        end
        if (op == mem_pkg::OP_SH) begin
            return r2[15:0] * 32'h0001_0001;
        end
        return r2;
    endfunction

    function automatic logic [31:0] exp_load(input mem_pkg::mem_op_e op, input logic [31:0] word,
                                             input logic [1:0] off);
        logic [31:0] sh;
        sh = word >> (8 * off);
        case (op)
            mem_pkg::OP_LB:  return {{24{sh[7]}}, sh[7:0]};
            mem_pkg::OP_LBU: return {24'h0, sh[7:0]};
            mem_pkg::OP_LH:  return {{16{sh[15]}}, sh[15:0]};
            mem_pkg::OP_LHU: return {16'h0, sh[15:0]};
            default:         return word;
        endcase
    endfunction

    function automatic mem_pkg::exc_code_e exp_exc(input logic [4:0] flags);
        logic [31:0] st;
        logic [31:0] ca;
        logic [31:0] wmask;
        // IP1:0 plus WP and IV
        wmask = (32'h3 << 8) | (32'h3 << 22);
        st = cp0_status_i;
        ca = cp0_cause_i;
        if (wb_cp0_we_i && wb_cp0_addr_i == mem_pkg::CP0_REG_STATUS) begin
            st = wb_cp0_data_i;
        end
        if (wb_cp0_we_i && wb_cp0_addr_i == mem_pkg::CP0_REG_CAUSE) begin
            ca = (ca & ~wmask) | (wb_cp0_data_i & wmask);
        end
        if ((ca[15:8] & st[15:8]) != 8'h0 && !st[1] && st[0]) return mem_pkg::EXC_INT;
        if (flags[mem_pkg::FLAG_SYS]) return mem_pkg::EXC_SYS;
        if (flags[mem_pkg::FLAG_RI]) return mem_pkg::EXC_RI;
        if (flags[mem_pkg::FLAG_TR]) return mem_pkg::EXC_TR;
        if (flags[mem_pkg::FLAG_OV]) return mem_pkg::EXC_OV;
        if (flags[mem_pkg::FLAG_ERET]) return mem_pkg::EXC_ERET;
        return mem_pkg::EXC_NONE;
    endfunction

    task automatic set_cp0(input logic [31:0] st, input logic [31:0] ca, input logic we,
                           input logic [4:0] ad, input logic [31:0] d);
        @(posedge clk);
        cp0_status_i  <= st;
        cp0_cause_i   <= ca;
        wb_cp0_we_i   <= we;
        wb_cp0_addr_i <= ad;
        wb_cp0_data_i <= d;
    endtask

    // one instruction through the stage, memory answering after a random delay
    task automatic do_access(input mem_pkg::mem_op_e op, input logic [31:0] addr,
                             input logic [31:0] r2, input logic [4:0] flags,
                             input int dly_bits, output logic [31:0] wb);
        mem_pkg::exc_code_e exc_e;
        logic        is_ld;
        logic        is_st;
        logic        ce_e;
        logic [3:0]  sel_e;
        logic [31:0] st_e;
        logic [31:0] wdata_e;
        logic [31:0] rnd;
        logic [31:0] v;
        int          dly;
        int          k;
        int          n;
        draw(32, rnd);
        @(posedge clk);
        inst_valid_i <= 1'b1;
        op_i         <= op;
        mem_addr_i   <= addr;
        reg2_i       <= r2;
        exc_flags_i  <= flags;
        wd_i         <= rnd[4:0];
        wreg_i       <= rnd[5];
        wdata_i      <= rnd;
        exc_e = exp_exc(flags);
        is_ld = op inside {mem_pkg::OP_LB, mem_pkg::OP_LBU, mem_pkg::OP_LH, mem_pkg::OP_LHU,
                           mem_pkg::OP_LW, mem_pkg::OP_LL};
        is_st = (op inside {mem_pkg::OP_SB, mem_pkg::OP_SH, mem_pkg::OP_SW})
             || (op == mem_pkg::OP_SC && link_m);
        ce_e  = (exc_e == mem_pkg::EXC_NONE) && (is_ld || is_st);
        sel_e = exp_sel(op, addr[1:0]);
        st_e  = exp_store(op, r2);
        @(negedge clk);
        check_val("exc_o", 32'(exc_o), 32'(exc_e));
        check_val("dmem_ce_o", 32'(dmem_ce_o), 32'(ce_e));
        check_val("dmem_we_o", 32'(dmem_we_o), 32'(ce_e && is_st));
        check_val("wd_o", 32'(wd_o), 32'(rnd[4:0]));
        check_val("wreg_o", 32'(wreg_o), 32'(rnd[5]));
        if (ce_e) begin
            check_val("dmem_addr_o", dmem_addr_o, addr & ~32'h3);
            check_val("dmem_sel_o", 32'(dmem_sel_o), 32'(sel_e));
            if (is_st) begin
                check_val("dmem_wdata_o", dmem_wdata_o, st_e);
            end
            draw(dly_bits, v);
            dly = int'(v);
            for (k = 0; k <= dly; k++) begin
                check_val("stall_o", 32'(stall_o), 32'd1);
                if (k < dly) begin
                    @(negedge clk);
                end
            end
            @(posedge clk);
            if (is_st) begin
                dmem_bvalid_i <= 1'b1;
            end else begin
                dmem_rdata_i  <= mem[addr[5:2]];
                dmem_rvalid_i <= 1'b1;
            end
            @(negedge clk);
            n = 0;
            while (stall_o && n < 8) begin
                @(negedge clk);
                n++;
            end
            if (stall_o) begin
                $display("timeout: stall_o stayed high after the memory response");
                errors++;
            end else begin
                assert (n == 0) else begin
                    $display("stall_o fell %0d cycles after the response instead of with it", n);
                    errors++;
                end
            end
        end else begin
            check_val("stall_o", 32'(stall_o), 32'd0);
        end
        wb = wdata_o;
        if (is_ld) begin
            wdata_e = exp_load(op, mem[addr[5:2]], addr[1:0]);
        end else if (op == mem_pkg::OP_SC) begin
            wdata_e = {31'h0, is_st};
        end else begin
            wdata_e = rnd;
        end
        if (exc_e == mem_pkg::EXC_NONE) begin
            check_val("wdata_o", wb, wdata_e);
        end
        if (ce_e && is_st) begin
            for (k = 0; k < 4; k++) begin
                if (sel_e[k]) begin
                    mem[addr[5:2]][8*k +: 8] = st_e[8*k +: 8];
                end
            end
        end
        // clear beats set
        if (exc_e == mem_pkg::EXC_ERET || (op == mem_pkg::OP_SC && ce_e)) begin
            link_m = 1'b0;
        end else if (op == mem_pkg::OP_LL && ce_e) begin
            link_m = 1'b1;
        end
        @(posedge clk);
        inst_valid_i  <= 1'b0;
        dmem_rvalid_i <= 1'b0;
        dmem_bvalid_i <= 1'b0;
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] r;
        logic [31:0] wb;
        int          i;
        int          off;
        int          f;
        rst_i         = 1'b1;
        inst_valid_i  = 1'b0;
        op_i          = mem_pkg::OP_NOP;
        mem_addr_i    = 32'h0;
        reg2_i        = 32'h0;
        wd_i          = 5'h0;
        wreg_i        = 1'b0;
        wdata_i       = 32'h0;
        exc_flags_i   = 5'h0;
        cp0_status_i  = 32'h0;
        cp0_cause_i   = 32'h0;
        wb_cp0_we_i   = 1'b0;
        wb_cp0_addr_i = 5'h0;
        wb_cp0_data_i = 32'h0;
        dmem_rdata_i  = 32'h0;
        dmem_rvalid_i = 1'b0;
        dmem_bvalid_i = 1'b0;
        lfsr_q        = 32'hbcf9_aa85;
        link_m        = 1'b0;
        errors        = 0;
        sva_errors    = 0;
        tests         = 0;
        test_start    = 0;
        for (i = 0; i < 16; i++) begin
            draw(32, mem[i]);
        end
        repeat (10) @(posedge clk);
        rst_i <= 1'b0;

        @(negedge clk);
        check_val("dmem_ce_o", 32'(dmem_ce_o), 32'd0);
        check_val("dmem_we_o", 32'(dmem_we_o), 32'd0);
        check_val("wreg_o", 32'(wreg_o), 32'd0);
        check_val("stall_o", 32'(stall_o), 32'd0);
        check_val("exc_o", 32'(exc_o), 32'(mem_pkg::EXC_NONE));
        // link bit starts clear
        draw(32, a);
        do_access(mem_pkg::OP_SC, {a[31:2], 2'b00}, a, 5'h0, 3, wb);
        check_val("wdata_o", wb, 32'd0);
        finish_test("reset");

        for (i = 0; i < 5; i++) begin
            for (off = 0; off < 4; off++) begin
                if (legal_off(load_list[i], off[1:0])) begin
                    draw(32, a);
                    draw(32, r);
                    mem[a[5:2]] = r;
                    do_access(load_list[i], {a[31:2], off[1:0]}, 32'h0, 5'h0, 3, wb);
                end
            end
        end
        finish_test("loads");

        for (i = 0; i < 3; i++) begin
            for (off = 0; off < 4; off++) begin
                if (legal_off(store_list[i], off[1:0])) begin
                    draw(32, a);
                    draw(32, r);
                    do_access(store_list[i], {a[31:2], off[1:0]}, r, 5'h0, 3, wb);
                    do_access(mem_pkg::OP_LW, {a[31:2], 2'b00}, 32'h0, 5'h0, 3, wb);
                end
            end
        end
        finish_test("stores");

        for (i = 0; i < 8; i++) begin
            draw(32, a);
            draw(32, r);
            if (r[0]) begin
                do_access(mem_pkg::OP_SW, a, r, 5'h0, 4, wb);
            end else begin
                do_access(mem_pkg::OP_LW, a, r, 5'h0, 4, wb);
            end
        end
        finish_test("stall");

        draw(32, a);
        draw(32, r);
        do_access(mem_pkg::OP_LL, {a[31:2], 2'b00}, 32'h0, 5'h0, 3, wb);
        do_access(mem_pkg::OP_SC, {a[31:2], 2'b00}, r, 5'h0, 3, wb);
        check_val("wdata_o", wb, 32'd1);
        do_access(mem_pkg::OP_SC, {a[31:2], 2'b00}, r, 5'h0, 3, wb);
        check_val("wdata_o", wb, 32'd0);
        do_access(mem_pkg::OP_LL, {a[31:2], 2'b00}, 32'h0, 5'h0, 3, wb);
        do_access(mem_pkg::OP_NOP, 32'h0, 32'h0, 5'h1 << mem_pkg::FLAG_ERET, 3, wb);
        do_access(mem_pkg::OP_SC, {a[31:2], 2'b00}, r, 5'h0, 3, wb);
        check_val("wdata_o", wb, 32'd0);
        finish_test("ll_sc");

        for (f = 0; f < 32; f++) begin
            draw(32, a);
            draw(32, r);
            do_access(mem_pkg::OP_SW, a, r, f[4:0], 3, wb);
        end
        // forwarded cause write raises the interrupt over a syscall
        set_cp0(32'h0000_0101, 32'h0, 1'b1, mem_pkg::CP0_REG_CAUSE, 32'h0000_0100);
        do_access(mem_pkg::OP_SB, a, r, 5'h01, 3, wb);
        set_cp0(32'h0000_0103, 32'h0, 1'b1, mem_pkg::CP0_REG_CAUSE, 32'h0000_0100);
        do_access(mem_pkg::OP_SB, a, r, 5'h01, 3, wb);
        set_cp0(32'h0000_ff01, 32'h0, 1'b1, mem_pkg::CP0_REG_CAUSE, 32'h0000_fc00);
        do_access(mem_pkg::OP_SB, a, r, 5'h01, 3, wb);
        set_cp0(32'h0, 32'h0000_0200, 1'b1, mem_pkg::CP0_REG_STATUS, 32'h0000_0201);
        do_access(mem_pkg::OP_SB, a, r, 5'h00, 3, wb);
        set_cp0(32'h0, 32'h0, 1'b0, 5'h0, 32'h0);
        finish_test("exceptions");

        @(posedge clk);
        $display("%0d tests run, %0d failed checks, %0d failed properties",
                 tests, errors, sva_errors);
        if (errors == 0 && sva_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
